// File: async_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module async_fifo (
   // write side
   input  wire                  wclk,
   input  wire                  write_en,
   input  wire cdc_pkg::data_t  data_in,
   output logic                 full,
   output cdc_pkg::level_t      level_w,

   // read side
   input  wire                  rclk,
   input  wire                  read_en,
   output cdc_pkg::data_t       data_out,
   output logic                 empty,
   output cdc_pkg::level_t      level_r,

   // shared async reset for both domains
   input  wire                  rst
);

   // gray pointers crossing between domains
   cdc_pkg::ptr_t  wr_gray;
   cdc_pkg::ptr_t  rd_gray;

   // storage addresses and qualified strobes
   cdc_pkg::addr_t wr_addr;
   cdc_pkg::addr_t rd_addr;
   logic           wr_accept;
   logic           rd_accept;

   fifo_wr_ctrl wr_ctrl_i (
      .wclk     (wclk),
      .rst      (rst),
      .write_en (write_en),
      .rd_gray  (rd_gray),
      .wr_gray  (wr_gray),
      .wr_addr  (wr_addr),
      .wr_accept(wr_accept),
      .full     (full),
      .level_w  (level_w)
   );

   fifo_rd_ctrl rd_ctrl_i (
      .rclk     (rclk),
      .rst      (rst),
      .read_en  (read_en),
      .wr_gray  (wr_gray),
      .rd_gray  (rd_gray),
      .rd_addr  (rd_addr),
      .rd_accept(rd_accept),
      .empty    (empty),
      .level_r  (level_r)
   );

   // storage relies on the controllers for full and empty gating
   fifo_mem mem_i (
      .wclk     (wclk),
      .wr_accept(wr_accept),
      .wr_addr  (wr_addr),
      .data_in  (data_in),
      .rclk     (rclk),
      .rst      (rst),
      .rd_accept(rd_accept),
      .rd_addr  (rd_addr),
      .data_out (data_out)
   );

endmodule

`default_nettype wire

// File: async_fifo_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_macros.svh"

module async_fifo_chk (
   input wire                   wclk,
   input wire                   rclk,
   input wire                   rst,
   input wire                   write_en,
   input wire                   full,
   input wire                   empty,
   input wire cdc_pkg::level_t  level_w,
   input wire cdc_pkg::level_t  level_r,
   input wire cdc_pkg::data_t   data_out
);

   // each side lags the other by only a few cycles
   // far less than the depth, so both flags cannot hold at once
   full_empty_excl: assert property (@(posedge wclk) disable iff (rst) !(full && empty))
      else $error("full and empty are high together");

   level_w_range: assert property (@(posedge wclk) disable iff (rst)
      level_w <= cdc_pkg::level_t'(`CDC_DEPTH))
      else $error("write level above depth");

   level_r_range: assert property (@(posedge rclk) disable iff (rst)
      level_r <= cdc_pkg::level_t'(`CDC_DEPTH))
      else $error("read level above depth");

   // a dropped write leaves the level alone, arriving reads can only lower it
   overflow_dropped: assert property (@(posedge wclk) disable iff (rst)
      (write_en && full) |=> (level_w <= $past(level_w)))
      else $error("write level rose on a write while full");

   underflow_hold: assert property (@(posedge rclk) disable iff (rst)
      empty |=> $stable(data_out))
      else $error("read data changed while empty");

endmodule

`default_nettype wire

// File: async_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_macros.svh"

module async_fifo_tb;

   localparam real wclk_period = 8.0;
   localparam real rclk_period = 11.0;
   // writes and reads of every test plus the settle gaps between them
   localparam int planned_ops = 10 + 10 + 20 + 16 + 3 + 2 + 200 + 6 * 5;

   logic             wclk;
   logic             rclk;
   logic             rst;
   logic             write_en;
   logic             read_en;
   cdc_pkg::data_t   data_in;
   cdc_pkg::data_t   data_out;
   logic             full;
   logic             empty;
   cdc_pkg::level_t  level_w;
   cdc_pkg::level_t  level_r;

   // model of the FIFO contents
   cdc_pkg::data_t   model_q [$];
   cdc_pkg::data_t   exp_data;
   logic             check_pending;
   int               wr_count;
   int               rd_count;
   int               error_count;
   int               check_count;
   int               test_count;
   int               errors_at_start;
   int               seed = 32'h21114f18;
   string            test_name;

   always #(wclk_period / 2) wclk = ~wclk;
   always #(rclk_period / 2) rclk = ~rclk;

   async_fifo async_fifo_i (
      .wclk    (wclk),
      .write_en(write_en),
      .data_in (data_in),
      .full    (full),
      .level_w (level_w),
      .rclk    (rclk),
      .read_en (read_en),
      .data_out(data_out),
      .empty   (empty),
      .level_r (level_r),
      .rst     (rst)
   );

   bind async_fifo async_fifo_chk chk_i (
      .wclk    (wclk),
      .rclk    (rclk),
      .rst     (rst),
      .write_en(write_en),
      .full    (full),
      .empty   (empty),
      .level_w (level_w),
      .level_r (level_r),
      .data_out(data_out)
   );

   // pops the oldest word in the model
   function automatic cdc_pkg::data_t expected_word();
      cdc_pkg::data_t word;
      word = model_q.pop_front();
      return word;
   endfunction

   // occupancy once both pointers have crossed
   function automatic int expected_settled_level();
      return wr_count - rd_count;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("** Error: %s %s expected %0h actual %0h",
                  test_name, what, expected, actual);
      end
   endtask

   // accepted writes as seen at the wclk edge
   always @(posedge wclk) begin
      if (!rst && write_en && !full) begin
         model_q.push_back(data_in);
         wr_count++;
      end
   end

   // accepted reads as seen at the rclk edge
   always @(posedge rclk) begin
      if (!rst && read_en && !empty) begin
         rd_count++;
         if (model_q.size() == 0) begin
            error_count++;
            $display("%s: a read was accepted with no word written", test_name);
         end else begin
            exp_data = expected_word();
            check_pending = 1'b1;
         end
      end
   end

   // data_out loads on the accepting edge and is compared half a cycle later
   always @(negedge rclk) begin
      if (check_pending) begin
         check_value("data_out", exp_data, data_out);
         check_pending = 1'b0;
      end
   end

   task automatic write_cycles(input int n, input bit random_en);
      logic [31:0] rnd;
      for (int i = 0; i < n; i++) begin
         @(negedge wclk);
         rnd = $random(seed);
         data_in = rnd[`CDC_DATA_W-1:0];
         write_en = random_en ? rnd[`CDC_DATA_W] : 1'b1;
      end
      @(negedge wclk);
      write_en = 1'b0;
   endtask

   task automatic read_cycles(input int n, input bit random_en);
      logic [31:0] rnd;
      for (int i = 0; i < n; i++) begin
         @(negedge rclk);
         rnd = $random(seed);
         read_en = random_en ? rnd[0] : 1'b1;
      end
      @(negedge rclk);
      read_en = 1'b0;
   endtask

   // hold read_en until n reads are accepted
   task automatic read_words(input int n);
      int target;
      int waited;
      target = rd_count + n;
      waited = 0;
      @(negedge rclk);
      read_en = 1'b1;
      while (rd_count < target && waited < n * 4 + 10) begin
         @(negedge rclk);
         waited++;
      end
      read_en = 1'b0;
      if (rd_count != target) begin
         error_count++;
         $display("%s: only %0d of %0d reads were accepted",
                  test_name, n - (target - rd_count), n);
      end
   endtask

   task automatic settle();
      repeat (6) @(negedge wclk);
      repeat (6) @(negedge rclk);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      errors_at_start = error_count;
      test_count++;
   endtask

   task automatic finish_test();
      @(negedge rclk);
      $display("test %0d %s finished with %0d errors",
               test_count, test_name, error_count - errors_at_start);
   endtask

   initial begin
      automatic int wr_base;
      automatic int rd_base;
      wclk = 1'b0;
      rclk = 1'b0;
      rst = 1'b1;
      write_en = 1'b0;
      read_en = 1'b0;
      data_in = '0;
      check_pending = 1'b0;
      wr_count = 0;
      rd_count = 0;
      error_count = 0;
      check_count = 0;
      test_count = 0;
      repeat (4) @(posedge wclk);
      @(negedge wclk);
      rst = 1'b0;
      settle();

      start_test("reset_state");
      check_value("empty", 1, empty);
      check_value("full", 0, full);
      check_value("level_w", 0, level_w);
      check_value("level_r", 0, level_r);
      check_value("data_out", 0, data_out);
      finish_test();

      start_test("ordered_transfer");
      write_cycles(10, 1'b0);
      read_words(10);
      check_value("empty", 1, empty);
      check_value("model depth", 0, model_q.size());
      finish_test();

      start_test("full_overflow");
      settle();
      wr_base = wr_count;
      write_cycles(20, 1'b0);
      check_value("full", 1, full);
      check_value("level_w", `CDC_DEPTH, level_w);
      check_value("accepted writes", `CDC_DEPTH, wr_count - wr_base);
      read_words(`CDC_DEPTH);
      check_value("empty", 1, empty);
      check_value("model depth", 0, model_q.size());
      finish_test();

      // data_out still holds the last word the model handed out
      start_test("underflow");
      settle();
      rd_base = rd_count;
      read_cycles(3, 1'b0);
      check_value("data_out", exp_data, data_out);
      check_value("level_r", 0, level_r);
      check_value("accepted reads", 0, rd_count - rd_base);
      write_cycles(1, 1'b0);
      read_words(1);
      finish_test();

      start_test("random_traffic");
      fork
         write_cycles(200, 1'b1);
         read_cycles(200, 1'b1);
      join
      finish_test();

      start_test("settled_levels");
      settle();
      check_value("level_w", expected_settled_level(), level_w);
      check_value("level_r", expected_settled_level(), level_r);
      finish_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // ends a hung run
   initial begin
      #(planned_ops * rclk_period * 4);
      $display("watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: cdc_macros.svh
`ifndef CDC_MACROS_SVH
`define CDC_MACROS_SVH

// width of one FIFO word
`define CDC_DATA_W 8

// memory address width
// pointers carry one extra wrap bit on top of this
`define CDC_ADDR_W 4

// number of storage entries
`define CDC_DEPTH (1 << `CDC_ADDR_W)

// flops in each pointer synchronizer
`define CDC_SYNC_STAGES 2

`endif

// File: cdc_pkg.sv
`default_nettype none

`include "cdc_macros.svh"

package cdc_pkg;

   // one FIFO word
   typedef logic [`CDC_DATA_W-1:0] data_t;

   // pointer with wrap bit, gray on the crossing and binary for arithmetic
   typedef logic [`CDC_ADDR_W:0] ptr_t;

   // fill count, 0 up to the full depth
   typedef logic [`CDC_ADDR_W:0] level_t;

   // storage index
   typedef logic [`CDC_ADDR_W-1:0] addr_t;

   // each binary bit is the xor of all gray bits at or above it
   function automatic ptr_t gray_to_bin(input ptr_t gray);
      ptr_t bin;
      bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
      for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

// File: fifo_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_macros.svh"

module fifo_mem (
   input  wire                  wclk,
   input  wire                  wr_accept,
   input  wire cdc_pkg::addr_t  wr_addr,
   input  wire cdc_pkg::data_t  data_in,
   input  wire                  rclk,
   input  wire                  rst,
   input  wire                  rd_accept,
   input  wire cdc_pkg::addr_t  rd_addr,
   output cdc_pkg::data_t       data_out
);

   // storage array, written on wclk and read on rclk
   cdc_pkg::data_t mem [`CDC_DEPTH];

   // write port
   // accept is already gated by full in the write controller
   always_ff @(posedge wclk) begin
      if (wr_accept) begin
         mem[wr_addr] <= data_in;
      end
   end

   // registered read port
   // the word at rd_addr is the oldest one, loaded on the accepting edge
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         data_out <= '0;
      end else if (rd_accept) begin
         data_out <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// File: fifo_rd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_macros.svh"

module fifo_rd_ctrl (
   input  wire                  rclk,
   input  wire                  rst,
   input  wire                  read_en,
   input  wire cdc_pkg::ptr_t   wr_gray,
   output cdc_pkg::ptr_t        rd_gray,
   output cdc_pkg::addr_t       rd_addr,
   output logic                 rd_accept,
   output logic                 empty,
   output cdc_pkg::level_t      level_r
);

   cdc_pkg::ptr_t rd_bin;
   cdc_pkg::ptr_t wr_sync [`CDC_SYNC_STAGES];
   cdc_pkg::ptr_t wr_bin;

   // read pointer, advances once per accepted word
   gray_counter #(
      .width($bits(cdc_pkg::ptr_t))
   ) rd_cnt_i (
      .clk (rclk),
      .rst (rst),
      .en  (rd_accept),
      .bin (rd_bin),
      .gray(rd_gray)
   );

   // bring the write pointer into the rclk domain
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
            wr_sync[i] <= '0;
         end
      end else begin
         wr_sync[0] <= wr_gray;
         for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
            wr_sync[i] <= wr_sync[i-1];
         end
      end
   end

   assign wr_bin = cdc_pkg::gray_to_bin(wr_sync[`CDC_SYNC_STAGES-1]);

   // synced write pointer lags, so this level errs low
   // a word is never seen before its write has settled in memory
   assign level_r = wr_bin - rd_bin;

   assign empty = (level_r == '0);

   // reads while empty are ignored here
   assign rd_accept = read_en & ~empty;

   // oldest word sits at the current read pointer
   assign rd_addr = rd_bin[`CDC_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: fifo_wr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cdc_macros.svh"

module fifo_wr_ctrl (
   input  wire                  wclk,
   input  wire                  rst,
   input  wire                  write_en,
   input  wire cdc_pkg::ptr_t   rd_gray,
   output cdc_pkg::ptr_t        wr_gray,
   output cdc_pkg::addr_t       wr_addr,
   output logic                 wr_accept,
   output logic                 full,
   output cdc_pkg::level_t      level_w
);

   cdc_pkg::ptr_t wr_bin;
   cdc_pkg::ptr_t rd_sync [`CDC_SYNC_STAGES];
   cdc_pkg::ptr_t rd_bin;

   // write pointer, advances once per accepted word
   gray_counter #(
      .width($bits(cdc_pkg::ptr_t))
   ) wr_cnt_i (
      .clk (wclk),
      .rst (rst),
      .en  (wr_accept),
      .bin (wr_bin),
      .gray(wr_gray)
   );

   // bring the read pointer into the wclk domain
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `CDC_SYNC_STAGES; i++) begin
            rd_sync[i] <= '0;
         end
      end else begin
         rd_sync[0] <= rd_gray;
         for (int i = 1; i < `CDC_SYNC_STAGES; i++) begin
            rd_sync[i] <= rd_sync[i-1];
         end
      end
   end

   assign rd_bin = cdc_pkg::gray_to_bin(rd_sync[`CDC_SYNC_STAGES-1]);

   // the synced read pointer lags, so this level errs high
   // wrap bit makes the subtraction modulo twice the depth
   assign level_w = wr_bin - rd_bin;

   // full at exactly the depth, all entries in use
   assign full = (level_w == cdc_pkg::level_t'(`CDC_DEPTH));

   // writes while full are dropped here
   assign wr_accept = write_en & ~full;

   assign wr_addr = wr_bin[`CDC_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: gray_counter.sv
`timescale 1ns/100ps
`default_nettype none

module gray_counter #(
   parameter int width = 5
) (
   input  wire               clk,
   input  wire               rst,
   input  wire               en,
   output logic [width-1:0]  bin,
   output logic [width-1:0]  gray
);

   logic [width-1:0] bin_next;

   // count after this step
   assign bin_next = bin + 1'b1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin  <= '0;
         gray <= '0;
      end else if (en) begin
         bin  <= bin_next;
         // encode the new count so gray and bin always agree
         // only one bit of gray flips per step, and it comes straight from a flop
         gray <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module async_fifo_tb \
   -f sim.f \
   -o async_fifo_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

output=$(./obj_dir/async_fifo_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "Simulation completed successfully" <<< "$output"; then
   echo "result: pass"
   exit 0
else
   echo "result: fail"
   exit 1
fi

// File: sim.f
+incdir+.
cdc_pkg.sv
gray_counter.sv
fifo_mem.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
async_fifo_chk.sv
async_fifo_tb.sv
